// File: bench/tb_note_tuner.sv
`timescale 1ns/1ps
`include "tuner_params.svh"

module tb_note_tuner;

    import tuner_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int TONE_PERIODS   = 40;
    localparam int SETTLE_PERIODS = 14;
    localparam int NUM_TONES      = 12;
    localparam int TOP            = `TUNER_DIGITS - 1;
    localparam int SCAN_LIMIT     = 4 * `TUNER_DIGITS * `TUNER_SCAN_DIV;

    // Lowest octave, C first, in hundredths of a Hz
    localparam longint FREQ_100 [12] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    logic                     clk = 1'b0;
    logic                     rst;
    mic_sample_t              mic;
    logic                     mic_ready;
    logic                     freeze;
    logic                     cfg_we;
    logic [1:0]               cfg_addr;
    level_t                   cfg_data;
    period_t                  period;
    note_code_t               note_code;
    seg_t                     abcdefgh;
    logic [`TUNER_DIGITS-1:0] digit;

    integer      seed = 32'h3998ac73;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    longint      budget_cycles = 0;
    int          tone_p    [15];
    int          tone_code [15];
    mic_sample_t tone_amp  [15];

    note_tuner_top note_tuner_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic longint clamp(input longint v, input longint lo, input longint hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    function automatic longint window_bound(input int semitone, input int octave,
                                            input longint pct);
        return longint'(`TUNER_CLK_HZ) * pct / (FREQ_100[semitone] << octave);
    endfunction

    // Settled count is P-1 and the four truncating stages take up to four more
    function automatic int tone_period(input int semitone, input int octave);
        longint low;
        longint high;
        low  = window_bound(semitone, octave, 97);
        high = window_bound(semitone, octave, 103);
        return int'((low + high + 64'd6) / 2);
    endfunction

    // Lit segments of each hex glyph, a in the top bit
    function automatic seg_t glyph(input logic [3:0] hex);
        string lit;
        seg_t  seg;
        case (hex)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcdfg";
            4'ha: lit = "abcefg";
            4'hb: lit = "cdefg";
            4'hc: lit = "adef";
            4'hd: lit = "bcdeg";
            4'he: lit = "adefg";
            default: lit = "aefg";
        endcase
        seg = '0;
        for (int i = 0; i < lit.len(); i++)
            seg = seg | (8'h80 >> (int'(lit[i]) - 97));
        return seg;
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic pick_tone(input int idx, input int semitone);
        tone_p[idx]    = tone_period(semitone, rand_below(2));
        tone_code[idx] = 12 - semitone;
        tone_amp[idx]  = mic_sample_t'('h1000 + rand_below('h3f000));
    endtask

    // Square wave, positive half first, one sample per clock
    task automatic play_tone(input int idx, input int periods);
        for (int n = 0; n < periods; n++)
        begin
            for (int k = 0; k < tone_p[idx]; k++)
            begin
                mic_ready = 1'b1;
                mic       = (k < tone_p[idx] / 2) ? tone_amp[idx] : -tone_amp[idx];
                @(posedge clk);
                #5;
            end
        end
        mic_ready = 1'b0;
        mic       = '0;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input level_t data);
        cfg_we   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        @(posedge clk);
        #5;
        cfg_we = 1'b0;
    endtask

    task automatic check_tone(input string name, input int idx);
        longint p;
        p = longint'(tone_p[idx]);
        check_value({name, " note_code"}, longint'(tone_code[idx]), longint'(note_code));
        check_value({name, " period"}, clamp(longint'(period), p - 64'd5, p - 64'd1),
                    longint'(period));
    endtask

    task automatic check_top_digit(input string name, input seg_t expected);
        int n;
        n = 0;
        @(negedge clk);
        while (!digit[TOP] && n < SCAN_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (digit[TOP])
        begin
            check_value({name, " digit"}, longint'(64'd1 << TOP), longint'(digit));
            check_value(name, longint'(expected), longint'(abcdefgh));
        end
        else
        begin
            errors++;
            $display("%s: display scan never reached the top digit", name);
        end
        @(posedge clk);
        #5;
    endtask

    //------------------------------------------------------------
    // Watchdog
    //------------------------------------------------------------

    initial
    begin
        wait (budget_cycles != 0);
        #(budget_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", budget_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    //------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------

    initial
    begin
        int         semitone;
        period_t    old_period;
        note_code_t old_code;
        longint     tone_cycles;
        string      name;

        rst       = 1'b1;
        mic       = '0;
        mic_ready = 1'b0;
        freeze    = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;

        // All tones drawn up front so the run length is known
        semitone = 0;
        for (int i = 0; i < NUM_TONES; i++)
        begin
            semitone = rand_below(12);
            pick_tone(i, semitone);
        end
        semitone = (semitone + 1 + rand_below(11)) % 12;
        pick_tone(12, semitone);
        semitone = (semitone + 1 + rand_below(11)) % 12;
        pick_tone(13, semitone);
        // Longer than the widest window, the low C
        tone_p[14]    = int'(window_bound(0, 0, 103)) + 60 + rand_below(200);
        tone_code[14] = 0;
        tone_amp[14]  = mic_sample_t'('h2000);

        tone_cycles = 0;
        for (int i = 0; i < 15; i++)
            tone_cycles += longint'(TONE_PERIODS * tone_p[i]);
        tone_cycles += longint'((TONE_PERIODS + SETTLE_PERIODS + 2) * tone_p[12]);
        budget_cycles = 4 * (tone_cycles + 64'd2000);

        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        check_value("reset_values period", 0, longint'(period));
        check_value("reset_values note_code", 0, longint'(note_code));
        check_value("reset_values abcdefgh", 0, longint'(abcdefgh));
        check_value("reset_values digit", 0, longint'(digit));
        end_test("reset_values");

        for (int i = 0; i < NUM_TONES; i++)
        begin
            name = $sformatf("tone_%0d", i);
            play_tone(i, TONE_PERIODS);
            check_tone(name, i);
            end_test(name);
        end

        // Threshold above every amplitude mutes the meter
        old_period = period;
        old_code   = note_code;
        write_cfg(2'd0, 24'h7fffff);
        play_tone(12, TONE_PERIODS);
        check_value("threshold period", longint'(old_period), longint'(period));
        check_value("threshold note_code", longint'(old_code), longint'(note_code));
        write_cfg(2'd0, level_t'(`TUNER_LEVEL_RESET));
        // First crossing carries the muted gap, so the later stages still lag
        play_tone(12, SETTLE_PERIODS);
        write_cfg(2'd1, 24'd0);
        play_tone(12, 2);
        check_value("stage_zero period",
                    clamp(longint'(period), longint'(tone_p[12] - 2), longint'(tone_p[12])),
                    longint'(period));
        write_cfg(2'd1, 24'd3);
        play_tone(12, TONE_PERIODS);
        check_tone("threshold resume", 12);
        end_test("threshold_and_stage");

        check_top_digit("display live", glyph(4'(tone_code[12])));
        freeze = 1'b1;
        play_tone(13, TONE_PERIODS);
        check_value("display note_code", longint'(tone_code[13]), longint'(note_code));
        check_top_digit("display frozen", glyph(4'(tone_code[12])));
        freeze = 1'b0;
        // Number reloads on the next clock
        @(posedge clk);
        #5;
        check_top_digit("display released", glyph(4'(tone_code[13])));
        end_test("display");

        play_tone(14, TONE_PERIODS);
        check_tone("out_of_window", 14);
        end_test("out_of_window");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/tuner_pkg.sv
rtl/tuner_config.sv
rtl/period_meter.sv
rtl/note_classifier.sv
rtl/note_filter.sv
rtl/seven_segment_display.sv
rtl/note_tuner_top.sv
bench/tb_note_tuner.sv

// File: rtl/note_classifier.sv
`timescale 1ns/1ps
`include "tuner_params.svh"

module note_classifier
(
    input  logic               clk,
    input  logic               rst,
    input  tuner_pkg::period_t period,
    output tuner_pkg::note_t   note
);

    import tuner_pkg::*;

    // Base octave in hundredths of a Hz, C first
    localparam longint unsigned FREQ_100 [12] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    // Period in clocks scaled by pct percent
    function automatic period_t bound(input longint unsigned freq_100,
                                      input longint unsigned pct);
        longint unsigned clocks;
        clocks = longint'(`TUNER_CLK_HZ) * pct / freq_100;
        return period_t'(clocks);
    endfunction

    note_t hit;

    //------------------------------------------------------------
    // Window compare, three octaves per semitone
    //------------------------------------------------------------

    for (genvar s = 0; s < 12; s++)
    begin : g_semitone
        logic [2:0] in_window;

        for (genvar o = 0; o < 3; o++)
        begin : g_octave
            localparam longint unsigned FREQ = FREQ_100[s] << o;
            localparam period_t LOW  = bound(FREQ, 97);
            localparam period_t HIGH = bound(FREQ, 103);

            assign in_window[o] = (period > LOW) && (period < HIGH);
        end

        assign hit[`TUNER_NOTE_W-1-s] = |in_window;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            note <= '0;
        else
            note <= hit;
    end

    // Windows of neighbouring semitones never overlap
    assert property (@(posedge clk) disable iff (rst) $onehot0(note));

endmodule

// File: rtl/note_filter.sv
`timescale 1ns/1ps

module note_filter
(
    input  logic             clk,
    input  logic             rst,
    input  tuner_pkg::note_t note,
    input  tuner_pkg::hold_t hold,
    output tuner_pkg::note_t held_note
);

    import tuner_pkg::*;

    note_t d_note;
    hold_t same_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            d_note    <= '0;
            same_cnt  <= '0;
            held_note <= '0;
        end
        else
        begin
            d_note <= note;

            // Count consecutive cycles of an unchanged note
            if (note != d_note)
                same_cnt <= '0;
            else if (same_cnt != '1)
                same_cnt <= same_cnt + 1'b1;

            if (same_cnt > hold)
                held_note <= d_note;
        end
    end

endmodule

// File: rtl/note_tuner_top.sv
`timescale 1ns/1ps
`include "tuner_params.svh"

module note_tuner_top
(
    input  logic                    clk,
    input  logic                    rst,
    input  tuner_pkg::mic_sample_t  mic,
    input  logic                    mic_ready,
    input  logic                    freeze,
    input  logic                    cfg_we,
    input  logic [1:0]              cfg_addr,
    input  tuner_pkg::level_t       cfg_data,
    output tuner_pkg::period_t      period,
    output tuner_pkg::note_code_t   note_code,
    output tuner_pkg::seg_t         abcdefgh,
    output logic [`TUNER_DIGITS-1:0] digit
);

    import tuner_pkg::*;

    level_t threshold;
    stage_t stage;
    hold_t  hold;
    level_t level;
    note_t  note;
    note_t  held_note;

    tuner_config tuner_config_inst (.*);

    period_meter period_meter_inst (.*);

    note_classifier note_classifier_inst (.*);

    note_filter note_filter_inst (.*);

    // One-hot note to display code, B at bit 0 gives 1
    always_comb
    begin
        note_code = '0;
        for (int i = 0; i < `TUNER_NOTE_W; i++)
        begin
            if (held_note == note_t'(1) << i)
                note_code = note_code_t'(i + 1);
        end
    end

    seven_segment_display seven_segment_display_inst (.*);

endmodule

// File: rtl/period_meter.sv
`timescale 1ns/1ps
`include "tuner_params.svh"

module period_meter
(
    input  logic                   clk,
    input  logic                   rst,
    input  tuner_pkg::mic_sample_t mic,
    input  logic                   mic_ready,
    input  tuner_pkg::level_t      threshold,
    input  tuner_pkg::stage_t      stage,
    output tuner_pkg::level_t      level,
    output tuner_pkg::period_t     period
);

    import tuner_pkg::*;

    localparam int SIGN = `TUNER_MIC_W - 1;

    level_t  level_avg   [4];
    level_t  level_next  [4];
    period_t period_avg  [4];
    period_t period_next [4];
    period_t counter;
    logic    prev_sign;
    logic    above;
    logic    crossing;

    // Half of a plus half of b, rounded down once
    function automatic level_t half_sum(input level_t a, input level_t b);
        logic [`TUNER_MIC_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[`TUNER_MIC_W:1];
    endfunction

    //------------------------------------------------------------
    // Next values of both averaging chains
    //------------------------------------------------------------

    always_comb
    begin
        level_next[0]  = half_sum(level_avg[0], level_t'(mic));
        period_next[0] = period_t'(half_sum(level_t'(period_avg[0]), level_t'(counter)));
        for (int i = 1; i < 4; i++)
        begin
            level_next[i]  = half_sum(level_avg[i], level_avg[i-1]);
            period_next[i] = period_t'(half_sum(level_t'(period_avg[i]),
                                                level_t'(period_avg[i-1])));
        end
    end

    assign level    = level_avg[3];
    assign above    = level > threshold;

    // Upward zero crossing while the signal is loud enough
    assign crossing = mic_ready && above && prev_sign && !mic[SIGN];

    //------------------------------------------------------------
    // Level chain, crossing counter and period chain
    //------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            level_avg  <= '{default: '0};
            period_avg <= '{default: '0};
            counter    <= '0;
            prev_sign  <= 1'b0;
            period     <= '0;
        end
        else
        begin
            if (crossing)
                counter <= '0;
            else if (counter != '1)
                counter <= counter + 1'b1;

            // Only non-negative samples feed the level
            if (mic_ready && !mic[SIGN])
                level_avg <= level_next;

            if (mic_ready && above)
                prev_sign <= mic[SIGN];

            if (crossing)
            begin
                period_avg <= period_next;
                period     <= period_next[stage];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (&counter && !crossing) |=> (counter != '0));

endmodule

// File: rtl/seven_segment_display.sv
`timescale 1ns/1ps
`include "tuner_params.svh"

module seven_segment_display
(
    input  logic                      clk,
    input  logic                      rst,
    input  tuner_pkg::note_code_t     note_code,
    input  tuner_pkg::level_t         level,
    input  logic                      freeze,
    output tuner_pkg::seg_t           abcdefgh,
    output logic [`TUNER_DIGITS-1:0]  digit
);

    import tuner_pkg::*;

    localparam int IDX_W  = $clog2(`TUNER_DIGITS);
    localparam int SCAN_W = $clog2(`TUNER_SCAN_DIV);

    logic [`TUNER_DIGITS*4-1:0] number;
    logic [SCAN_W-1:0]          scan_cnt;
    logic [IDX_W-1:0]           idx;

    function automatic seg_t hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    //------------------------------------------------------------
    // Number latch and digit scan
    //------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            number   <= '0;
            scan_cnt <= '0;
            idx      <= '0;
            digit    <= '0;
        end
        else
        begin
            // Note in the top nibble, level in the low six
            if (!freeze)
                number <= {note_code, 4'h0, level};

            scan_cnt <= scan_cnt + 1'b1;
            if (scan_cnt == SCAN_W'(`TUNER_SCAN_DIV - 1))
            begin
                if (digit == '0 || idx == IDX_W'(`TUNER_DIGITS - 1))
                begin
                    idx   <= '0;
                    digit <= `TUNER_DIGITS'(1);
                end
                else
                begin
                    idx   <= idx + 1'b1;
                    digit <= digit << 1;
                end
            end
        end
    end

    // Blank until the first digit is enabled
    always_comb
    begin
        if (digit == '0)
            abcdefgh = '0;
        else
            abcdefgh = hex_to_seg(number[idx*4 +: 4]);
    end

    assert property (@(posedge clk) disable iff (rst) (digit != '0) |=> $onehot(digit));

endmodule

// File: rtl/tuner_config.sv
`timescale 1ns/1ps
`include "tuner_params.svh"

module tuner_config
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  logic [1:0]         cfg_addr,
    input  tuner_pkg::level_t  cfg_data,
    output tuner_pkg::level_t  threshold,
    output tuner_pkg::stage_t  stage,
    output tuner_pkg::hold_t   hold
);

    import tuner_pkg::*;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            threshold <= level_t'(`TUNER_LEVEL_RESET);
            stage     <= stage_t'(`TUNER_STAGE_RESET);
            hold      <= hold_t'(`TUNER_HOLD_RESET);
        end
        else if (cfg_we)
        begin
            // Address 3 is unused
            case (cfg_addr)
                2'd0:    threshold <= cfg_data;
                2'd1:    stage     <= cfg_data[1:0];
                2'd2:    hold      <= cfg_data[19:0];
                default: ;
            endcase
        end
    end

    // Stage drives a mux select downstream
    assert property (@(posedge clk) disable iff (rst) !$isunknown(stage));

endmodule

// File: rtl/tuner_params.svh
`ifndef TUNER_PARAMS_SVH
`define TUNER_PARAMS_SVH

// Clock rate in Hz
`define TUNER_CLK_HZ      100000

// Data path widths
`define TUNER_MIC_W       24
`define TUNER_PERIOD_W    20
`define TUNER_NOTE_W      12

// Display geometry and scan rate
`define TUNER_DIGITS      8
`define TUNER_SCAN_DIV    16

// Register reset values
`define TUNER_LEVEL_RESET 'h100
`define TUNER_STAGE_RESET 3
`define TUNER_HOLD_RESET  200

`endif

// File: rtl/tuner_pkg.sv
`include "tuner_params.svh"

package tuner_pkg;

    // One signed microphone sample
    typedef logic signed [`TUNER_MIC_W-1:0] mic_sample_t;

    // Smoothed positive level, same width as a sample
    typedef logic [`TUNER_MIC_W-1:0] level_t;

    // Period in clock cycles
    typedef logic [`TUNER_PERIOD_W-1:0] period_t;

    // One-hot semitone, C in the top bit and B in bit 0
    typedef logic [`TUNER_NOTE_W-1:0] note_t;

    // Display code, C is 12 down to B at 1, zero for no note
    typedef logic [3:0] note_code_t;

    // Averaging stage select
    typedef logic [1:0] stage_t;

    // Note hold count in cycles
    typedef logic [19:0] hold_t;

    // Segments abcdefgh, a in the top bit
    typedef logic [7:0] seg_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the note tuner testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_note_tuner \
        -f files.f -o tb_note_tuner; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_note_tuner)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
